// ==== src/fsa_pkg.sv ====
`default_nettype none

package fsa_pkg;

	localparam int PIXEL_W = 8;
	localparam int IMG_HW  = 12;
	localparam int IMG_WW  = 12;

	// bank geometry, one word per image row.
	localparam int BR_NUM = 4;
	localparam int BR_AW  = 12;
	localparam int BR_DW  = 32;

	// row word layout. bits above the hit flag stay zero.
	localparam int ROW_LEFT_LSB  = 0;
	localparam int ROW_RIGHT_LSB = 12;
	localparam int ROW_HIT_BIT   = 24;

	typedef logic [PIXEL_W-1:0] pixel_t;
	typedef logic [IMG_HW-1:0]  row_t;
	typedef logic [IMG_WW-1:0]  col_t;

	// one-hot bank select, zero selects nothing.
	typedef logic [BR_NUM-1:0] bank_map_t;

	typedef logic [BR_AW-1:0] br_addr_t;
	typedef logic [BR_DW-1:0] br_data_t;

endpackage

`default_nettype wire

// ==== src/block_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module block_ram
	import fsa_pkg::*;
(
	input  wire           clk,
	input  wire           wr_en,
	input  wire br_addr_t wr_addr,
	input  wire br_data_t wr_data,
	input  wire           rd_en,
	input  wire br_addr_t rd_addr,
	output br_data_t      rd_data
);

	br_data_t mem [2**BR_AW];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

// ==== src/mutex_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module mutex_buffer
	import fsa_pkg::*;
(
	input  wire  clk,
	input  wire  resetn,
	input  wire  w_sof,
	input  wire  w_done,
	output bank_map_t w_bmp,
	input  wire  r0_sof,
	output bank_map_t r0_bmp,
	input  wire  r1_sof,
	output bank_map_t r1_bmp
);

	bank_map_t latest;
	bank_map_t busy;
	bank_map_t free_bmp;

	// the writer may not touch the newest frame or anything a reader holds.
	assign busy = latest | r0_bmp | r1_bmp;

	// scan downward so the lowest free bank is the one left selected.
	always_comb begin
		free_bmp = '0;
		for (int b = BR_NUM - 1; b >= 0; b--) begin
			if (!busy[b]) begin
				free_bmp = bank_map_t'(1) << b;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			latest <= '0;
			w_bmp  <= '0;
			r0_bmp <= '0;
			r1_bmp <= '0;
		end else begin
			if (w_sof) begin
				w_bmp <= free_bmp;
			end
			if (w_done) begin
				latest <= w_bmp;
			end
			if (r0_sof) begin
				r0_bmp <= latest;
			end
			if (r1_sof) begin
				r1_bmp <= latest;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/fsa_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module fsa_core
	import fsa_pkg::*;
(
	input  wire         clk,
	input  wire         resetn,
	input  wire row_t   height,
	input  wire col_t   width,
	input  wire pixel_t ref_data,
	input  wire         s_axis_tvalid,
	input  wire         s_axis_tuser,
	input  wire         s_axis_tlast,
	input  wire pixel_t s_axis_tdata,
	output logic        s_axis_tready,
	output logic        sof,
	output logic        wr_done,
	output bank_map_t   wr_en,
	output br_addr_t    wr_addr,
	output br_data_t    wr_data,
	input  wire bank_map_t wr_bmp,
	output logic        ana_done,
	output col_t        lft_v,
	output col_t        rt_v
);

	logic     beat;
	logic     row_end;
	col_t     col_cnt;
	row_t     row_cnt;
	col_t     cur_col;
	row_t     cur_row;
	logic     qual;
	logic     row_hit;
	col_t     row_left;
	col_t     row_right;
	logic     prior_hit;
	logic     hit_n;
	col_t     left_n;
	col_t     right_n;
	logic     frm_hit;
	col_t     frm_min;
	col_t     frm_max;
	logic     prior_frm;
	col_t     frm_min_n;
	col_t     frm_max_n;
	logic     wr_req;
	logic     done_pend;
	br_data_t word_n;

	assign beat    = s_axis_tvalid & s_axis_tready;
	assign row_end = beat & s_axis_tlast;

	// a tuser beat is always column 0 of row 0, whatever the counters say.
	assign cur_col = s_axis_tuser ? '0 : col_cnt;
	assign cur_row = s_axis_tuser ? '0 : row_cnt;

	// pixels past the programmed width never qualify.
	assign qual = beat && (s_axis_tdata >= ref_data) && (cur_col < width);

	assign prior_hit = (cur_col != '0) && row_hit;
	assign hit_n     = prior_hit | qual;
	assign left_n    = prior_hit ? row_left : (qual ? cur_col : '0);
	assign right_n   = qual ? cur_col : (prior_hit ? row_right : '0);

	// frame bounds only look at rows that had a hit.
	assign prior_frm = (cur_row != '0) && frm_hit;
	assign frm_min_n = (hit_n && (!prior_frm || left_n < frm_min)) ? left_n :
	                   (prior_frm ? frm_min : '0);
	assign frm_max_n = (hit_n && (!prior_frm || right_n > frm_max)) ? right_n :
	                   (prior_frm ? frm_max : '0);

	always_comb begin
		word_n = '0;
		word_n[ROW_LEFT_LSB +: IMG_WW]  = left_n;
		word_n[ROW_RIGHT_LSB +: IMG_WW] = right_n;
		word_n[ROW_HIT_BIT]             = hit_n;
	end

	// the bank map arrives with the first row's write request.
	assign wr_en   = wr_req ? wr_bmp : '0;
	assign wr_done = ana_done;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			s_axis_tready <= 1'b0;
			col_cnt       <= '0;
			row_cnt       <= '0;
			row_hit       <= 1'b0;
			frm_hit       <= 1'b0;
			sof           <= 1'b0;
			wr_req        <= 1'b0;
			done_pend     <= 1'b0;
			ana_done      <= 1'b0;
			lft_v         <= '0;
			rt_v          <= '0;
		end else begin
			s_axis_tready <= 1'b1;
			sof           <= beat & s_axis_tuser;
			wr_req        <= row_end;
			done_pend     <= row_end && (row_t'(cur_row + 1'b1) == height);
			ana_done      <= done_pend;
			if (beat) begin
				col_cnt <= row_end ? '0 : col_t'(cur_col + 1'b1);
				row_cnt <= row_end ? row_t'(cur_row + 1'b1) : cur_row;
				row_hit <= hit_n;
			end
			if (row_end) begin
				frm_hit <= prior_frm | hit_n;
			end
			if (done_pend) begin
				lft_v <= frm_min;
				rt_v  <= frm_max;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (beat) begin
			row_left  <= left_n;
			row_right <= right_n;
		end
		if (row_end) begin
			frm_min <= frm_min_n;
			frm_max <= frm_max_n;
			wr_addr <= br_addr_t'(cur_row);
			wr_data <= word_n;
		end
	end

endmodule

`default_nettype wire

// ==== src/fsa_stream.sv ====
`timescale 1ns/100ps
`default_nettype none

module fsa_stream
	import fsa_pkg::*;
(
	input  wire           clk,
	input  wire           resetn,
	input  wire row_t     height,
	input  wire           fsync,
	output logic          rd_sof,
	output logic          rd_en,
	output br_addr_t      rd_addr,
	input  wire br_data_t rd_data,
	output logic          m_axis_tvalid,
	output br_data_t      m_axis_tdata,
	output logic          m_axis_tuser,
	output logic          m_axis_tlast,
	input  wire           m_axis_tready
);

	typedef enum logic [2:0] {
		idle,
		lock,
		read,
		wait_data,
		send
	} state_t;

	state_t     state;
	row_t       row;
	logic [1:0] lat;
	logic       last_row;
	logic       capture;

	assign rd_sof   = (state == lock);
	assign rd_en    = (state == read);
	assign rd_addr  = br_addr_t'(row);
	assign last_row = (row == row_t'(height - 1'b1));

	// the word is back in the reader register three cycles after rd_en.
	assign capture = (state == wait_data) && (lat == 2'd2);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state         <= idle;
			row           <= '0;
			lat           <= '0;
			m_axis_tvalid <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (fsync) begin
						state <= lock;
					end
				end
				lock: begin
					row   <= '0;
					state <= read;
				end
				read: begin
					lat   <= '0;
					state <= wait_data;
				end
				wait_data: begin
					lat <= lat + 1'b1;
					if (capture) begin
						m_axis_tvalid <= 1'b1;
						state         <= send;
					end
				end
				send: begin
					if (m_axis_tready) begin
						m_axis_tvalid <= 1'b0;
						if (last_row) begin
							state <= idle;
						end else begin
							row   <= row_t'(row + 1'b1);
							state <= read;
						end
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			m_axis_tdata <= rd_data;
			m_axis_tuser <= (row == '0);
			m_axis_tlast <= last_row;
		end
	end

endmodule

`default_nettype wire

// ==== src/fsa.sv ====
`timescale 1ns/100ps
`default_nettype none

module fsa
	import fsa_pkg::*;
(
	input  wire           clk,
	input  wire           resetn,
	input  wire row_t     height,
	input  wire col_t     width,
	input  wire           s_axis_tvalid,
	input  wire pixel_t   s_axis_tdata,
	input  wire           s_axis_tuser,
	input  wire           s_axis_tlast,
	output logic          s_axis_tready,
	input  wire pixel_t   ref_data,
	output logic          ana_done,
	output col_t          lft_v,
	output col_t          rt_v,
	input  wire           r_sof,
	input  wire           r_en,
	input  wire br_addr_t r_addr,
	output br_data_t      r_data,
	input  wire           fsync,
	output logic          m_axis_tvalid,
	output br_data_t      m_axis_tdata,
	output logic          m_axis_tuser,
	output logic          m_axis_tlast,
	input  wire           m_axis_tready
);

	logic      wr_sof;
	logic      wr_done;
	bank_map_t wr_en;
	br_addr_t  wr_addr;
	br_data_t  wr_data;
	bank_map_t wr_bmp;
	bank_map_t r0_bmp;
	bank_map_t r1_bmp;
	logic      s_rd_sof;
	logic      s_rd_en;
	br_addr_t  s_rd_addr;
	br_data_t  s_rd_data;
	br_data_t  bank_rdata [BR_NUM];

	// OR of the banks picked by a one-hot map. an empty map gives zero.
	function automatic br_data_t pick(input bank_map_t map);
		br_data_t word;
		word = '0;
		for (int b = 0; b < BR_NUM; b++) begin
			if (map[b]) begin
				word = word | bank_rdata[b];
			end
		end
		return word;
	endfunction

	for (genvar i = 0; i < BR_NUM; i++) begin : g_bank
		logic     s_hit;
		logic     en_q;
		br_addr_t addr_q;

		// the stream reader wins a bank when both readers want it.
		assign s_hit = s_rd_en && r1_bmp[i];

		always_ff @(posedge clk) begin
			if (!resetn) begin
				en_q <= 1'b0;
			end else begin
				en_q <= s_hit || (r_en && r0_bmp[i]);
			end
		end

		always_ff @(posedge clk) begin
			addr_q <= s_hit ? s_rd_addr : r_addr;
		end

		block_ram u_ram (
			.clk    (clk),
			.wr_en  (wr_en[i]),
			.wr_addr(wr_addr),
			.wr_data(wr_data),
			.rd_en  (en_q),
			.rd_addr(addr_q),
			.rd_data(bank_rdata[i])
		);
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			r_data    <= '0;
			s_rd_data <= '0;
		end else begin
			r_data    <= pick(r0_bmp);
			s_rd_data <= pick(r1_bmp);
		end
	end

	mutex_buffer u_mutex (
		.clk   (clk),
		.resetn(resetn),
		.w_sof (wr_sof),
		.w_done(wr_done),
		.w_bmp (wr_bmp),
		.r0_sof(r_sof),
		.r0_bmp(r0_bmp),
		.r1_sof(s_rd_sof),
		.r1_bmp(r1_bmp)
	);

	fsa_core u_core (
		.clk          (clk),
		.resetn       (resetn),
		.height       (height),
		.width        (width),
		.ref_data     (ref_data),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tuser (s_axis_tuser),
		.s_axis_tlast (s_axis_tlast),
		.s_axis_tdata (s_axis_tdata),
		.s_axis_tready(s_axis_tready),
		.sof          (wr_sof),
		.wr_done      (wr_done),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.wr_bmp       (wr_bmp),
		.ana_done     (ana_done),
		.lft_v        (lft_v),
		.rt_v         (rt_v)
	);

	fsa_stream u_stream (
		.clk          (clk),
		.resetn       (resetn),
		.height       (height),
		.fsync        (fsync),
		.rd_sof       (s_rd_sof),
		.rd_en        (s_rd_en),
		.rd_addr      (s_rd_addr),
		.rd_data      (s_rd_data),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tdata (m_axis_tdata),
		.m_axis_tuser (m_axis_tuser),
		.m_axis_tlast (m_axis_tlast),
		.m_axis_tready(m_axis_tready)
	);

endmodule

`default_nettype wire

// ==== sim/fsa_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module fsa_sva
	import fsa_pkg::*;
(
	input wire            clk,
	input wire            resetn,
	input wire            m_axis_tvalid,
	input wire            m_axis_tready,
	input wire br_data_t  m_axis_tdata,
	input wire            m_axis_tuser,
	input wire            m_axis_tlast,
	input wire            ana_done,
	input wire bank_map_t wr_en
);

	int fail_cnt = 0;

	// a stalled word must not change until the sink takes it.
	stream_hold: assert property (@(posedge clk) disable iff (!resetn)
		(m_axis_tvalid && !m_axis_tready) |=>
		(m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tuser) &&
		$stable(m_axis_tlast)))
	else begin
		fail_cnt = fail_cnt + 1;
		$error("stream word changed while stalled");
	end

	done_pulse: assert property (@(posedge clk) disable iff (!resetn)
		ana_done |=> !ana_done)
	else begin
		fail_cnt = fail_cnt + 1;
		$error("ana_done held high for two cycles");
	end

	// the core writes into one bank at most.
	wr_onehot: assert property (@(posedge clk) disable iff (!resetn)
		$onehot0(wr_en))
	else begin
		fail_cnt = fail_cnt + 1;
		$error("write enable selects more than one bank");
	end

endmodule

bind fsa fsa_sva u_sva (
	.clk          (clk),
	.resetn       (resetn),
	.m_axis_tvalid(m_axis_tvalid),
	.m_axis_tready(m_axis_tready),
	.m_axis_tdata (m_axis_tdata),
	.m_axis_tuser (m_axis_tuser),
	.m_axis_tlast (m_axis_tlast),
	.ana_done     (ana_done),
	.wr_en        (wr_en)
);

`default_nettype wire

// ==== sim/fsa_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module fsa_tb
	import fsa_pkg::*;
();

	localparam int     HEIGHT    = 8;
	localparam int     WIDTH     = 16;
	localparam int     TIMEOUT   = 2000;
	localparam pixel_t REF_LEVEL = 8'hf0;

	logic     clk;
	logic     resetn;
	row_t     height;
	col_t     width;
	logic     s_axis_tvalid;
	pixel_t   s_axis_tdata;
	logic     s_axis_tuser;
	logic     s_axis_tlast;
	logic     s_axis_tready;
	pixel_t   ref_data;
	logic     ana_done;
	col_t     lft_v;
	col_t     rt_v;
	logic     r_sof;
	logic     r_en;
	br_addr_t r_addr;
	br_data_t r_data;
	logic     fsync;
	logic     m_axis_tvalid;
	br_data_t m_axis_tdata;
	logic     m_axis_tuser;
	logic     m_axis_tlast;
	logic     m_axis_tready;

	integer   seed;
	int       done_cnt;
	pixel_t   pix [2][HEIGHT][WIDTH];
	br_data_t model [2][HEIGHT];
	col_t     exp_lft [2];
	col_t     exp_rt [2];

	fsa uut (.*);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		if (ana_done) begin
			done_cnt <= done_cnt + 1;
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1);
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("timed out at %0t waiting for %s", $time, what);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic next_cycle;
		@(posedge clk);
		#1;
	endtask

	// builds the pixels of a frame and the row words and bounds they should give.
	task automatic make_frame(input int slot, input int low_row, input bit empty);
		logic [31:0] rnd;
		bit          hit;
		bit          frm_hit;
		col_t        left;
		col_t        right;
		col_t        frm_min;
		col_t        frm_max;
		br_data_t    word;
		frm_hit = 1'b0;
		frm_min = '0;
		frm_max = '0;
		for (int r = 0; r < HEIGHT; r++) begin
			hit   = 1'b0;
			left  = '0;
			right = '0;
			for (int c = 0; c < WIDTH; c++) begin
				rnd = $random(seed);
				pix[slot][r][c] = (empty || r == low_row) ? (rnd[7:0] & 8'h7f) : rnd[7:0];
				if (pix[slot][r][c] >= REF_LEVEL) begin
					if (!hit) begin
						left = col_t'(c);
					end
					right = col_t'(c);
					hit   = 1'b1;
				end
			end
			word = '0;
			word[ROW_LEFT_LSB +: IMG_WW]  = left;
			word[ROW_RIGHT_LSB +: IMG_WW] = right;
			word[ROW_HIT_BIT]             = hit;
			model[slot][r] = word;
			if (hit) begin
				if (!frm_hit || left < frm_min) begin
					frm_min = left;
				end
				if (!frm_hit || right > frm_max) begin
					frm_max = right;
				end
				frm_hit = 1'b1;
			end
		end
		exp_lft[slot] = frm_min;
		exp_rt[slot]  = frm_max;
	endtask

	// sends a frame, waits for ana_done and checks the bounds and the pulse.
	task automatic run_frame(input int slot);
		int t;
		int cnt0;
		cnt0 = done_cnt;
		for (int r = 0; r < HEIGHT; r++) begin
			for (int c = 0; c < WIDTH; c++) begin
				s_axis_tvalid = 1'b1;
				s_axis_tdata  = pix[slot][r][c];
				s_axis_tuser  = (r == 0 && c == 0);
				s_axis_tlast  = (c == WIDTH - 1);
				t = 0;
				while (!s_axis_tready) begin
					if (t == TIMEOUT) begin
						fail_timeout("s_axis_tready");
					end else begin
						next_cycle();
						t++;
					end
				end
				next_cycle();
			end
		end
		s_axis_tvalid = 1'b0;
		s_axis_tuser  = 1'b0;
		s_axis_tlast  = 1'b0;
		t = 0;
		while (!ana_done) begin
			if (t == TIMEOUT) begin
				fail_timeout("ana_done");
			end else begin
				next_cycle();
				t++;
			end
		end
		check_value("lft_v", exp_lft[slot], lft_v);
		check_value("rt_v", exp_rt[slot], rt_v);
		// the buffer makes this frame the latest one on this edge.
		next_cycle();
		check_value("ana_done", 32'd0, ana_done);
		check_value("ana_done pulse count", cnt0 + 1, done_cnt);
	endtask

	task automatic lock_read_port;
		r_sof = 1'b1;
		next_cycle();
		r_sof = 1'b0;
	endtask

	task automatic read_row(input int row, input br_data_t expected);
		r_en   = 1'b1;
		r_addr = br_addr_t'(row);
		next_cycle();
		r_en = 1'b0;
		@(posedge clk);
		next_cycle();
		check_value("r_data", expected, r_data);
	endtask

	task automatic read_frame(input int slot);
		for (int r = 0; r < HEIGHT; r++) begin
			read_row(r, model[slot][r]);
		end
	endtask

	// tready is decided here, so a word seen with tready high is taken on the next edge.
	task automatic stream_frame(input int slot);
		logic [31:0] rnd;
		logic        rdy;
		int          got;
		int          t;
		fsync = 1'b1;
		next_cycle();
		fsync = 1'b0;
		got   = 0;
		t     = 0;
		while (got < HEIGHT) begin
			if (t == TIMEOUT) begin
				fail_timeout("stream words");
			end else begin
				rnd           = $random(seed);
				rdy           = rnd[0];
				m_axis_tready = rdy;
				if (m_axis_tvalid && rdy) begin
					check_value("m_axis_tdata", model[slot][got], m_axis_tdata);
					check_value("m_axis_tuser", got == 0, m_axis_tuser);
					check_value("m_axis_tlast", got == HEIGHT - 1, m_axis_tlast);
					got++;
				end
				next_cycle();
				t++;
			end
		end
		m_axis_tready = 1'b0;
		check_value("m_axis_tvalid", 32'd0, m_axis_tvalid);
	endtask

	task automatic test_reset_state;
		check_value("s_axis_tready", 32'd1, s_axis_tready);
		check_value("m_axis_tvalid", 32'd0, m_axis_tvalid);
		check_value("ana_done", 32'd0, ana_done);
		check_value("lft_v", 32'd0, lft_v);
		check_value("rt_v", 32'd0, rt_v);
		lock_read_port();
		for (int r = 0; r < 4; r++) begin
			read_row(r, '0);
		end
	endtask

	task automatic test_frame_analysis;
		make_frame(0, 3, 1'b0);
		run_frame(0);
		make_frame(1, -1, 1'b1);
		run_frame(1);
	endtask

	task automatic test_external_read;
		make_frame(0, 5, 1'b0);
		run_frame(0);
		lock_read_port();
		read_frame(0);
	endtask

	task automatic test_stream;
		stream_frame(0);
	endtask

	// frame A stays locked on the read port while two newer frames are written.
	task automatic test_bank_protection;
		lock_read_port();
		make_frame(1, 1, 1'b0);
		run_frame(1);
		read_frame(0);
		stream_frame(1);
		// frame A is neither the latest nor streamed now, only the read port holds it.
		make_frame(1, 6, 1'b0);
		run_frame(1);
		read_frame(0);
		lock_read_port();
		read_frame(1);
	endtask

	initial begin
		seed          = 32'hb27f_769d;
		clk           = 1'b0;
		resetn        = 1'b0;
		height        = row_t'(HEIGHT);
		width         = col_t'(WIDTH);
		ref_data      = REF_LEVEL;
		s_axis_tvalid = 1'b0;
		s_axis_tdata  = '0;
		s_axis_tuser  = 1'b0;
		s_axis_tlast  = 1'b0;
		r_sof         = 1'b0;
		r_en          = 1'b0;
		r_addr        = '0;
		fsync         = 1'b0;
		m_axis_tready = 1'b0;
		done_cnt      = 0;
		repeat (5) @(posedge clk);
		#1;
		resetn = 1'b1;
		next_cycle();
		test_reset_state();
		test_frame_analysis();
		test_external_read();
		test_stream();
		test_bank_protection();
		if (uut.u_sva.fail_cnt == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			$display("protocol assertions failed during the run");
			$display("STATUS: FAIL");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/fsa_pkg.sv
src/block_ram.sv
src/mutex_buffer.sv
src/fsa_core.sv
src/fsa_stream.sv
src/fsa.sv
sim/fsa_sva.sv
sim/fsa_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module fsa_tb --Mdir obj_dir \
	&& ./obj_dir/Vfsa_tb | tee /dev/stderr | grep -q "STATUS: PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
